/* rtl/fetchPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths and types for the fetch front end.
// Imported by every RTL block that handles PCs, bundles or predictions.
////////////////////////////////////////////////////////////////////////////

package fetchPkg;

  localparam int PC_WIDTH     = 32;                       // Byte address width.
  localparam int FETCH_WIDTH  = 4;                        // Slots per bundle.
  localparam int INST_WIDTH   = 32;                       // One instruction.
  localparam int BUNDLE_WIDTH = FETCH_WIDTH * INST_WIDTH; // 128 bits per bundle.

  // Control-transfer types, encoded as the training source sends them.
  typedef enum logic [1:0] {
    ctrlReturn     = 2'd0,
    ctrlCall       = 2'd1,
    ctrlJump       = 2'd2,
    ctrlCondBranch = 2'd3
  } ctrlType_e;

  // Cache refill FSM.
  typedef enum logic [1:0] {
    refillIdle, // No refill, watching for a miss.
    refillRead, // Beat on the bus, waiting for ack.
    refillDone  // Beat finished, bus released for one cycle.
  } refillState_e;

  // Lookup result for one slot of the bundle.
  typedef struct packed {
    logic                btbHit;   // Valid entry with matching tag.
    ctrlType_e           ctrlType; // Stored type.
    logic [PC_WIDTH-1:0] target;   // Stored target.
    logic                taken;    // Counter upper bit.
  } slotPred_t;

endpackage

/* rtl/branchUpdateIf.sv */
////////////////////////////////////////////////////////////////////////////
// Training update bus from the later pipeline stages.
// One update per cycle, in program order, to the BTB and the counters.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface branchUpdateIf import fetchPkg::*; ();

  logic                updateEn;     // Update this cycle.
  logic [PC_WIDTH-1:0] updatePc;     // Address of the control instruction.
  logic [PC_WIDTH-1:0] updateTarget; // Resolved target.
  ctrlType_e           updateType;   // Resolved type.
  logic                updateDir;    // Resolved direction, 1 = taken.

  // Driven from the top-level ports.
  modport source (output updateEn, updatePc, updateTarget, updateType, updateDir);

  // Each receiver filters the updates it cares about.
  modport sink (input updateEn, updatePc, updateTarget, updateType, updateDir);

endinterface

/* rtl/branchTargetBuffer.sv */
////////////////////////////////////////////////////////////////////////////
// Direct-mapped branch target buffer.
// Four combinational lookups per cycle, one for each slot of the bundle,
// and one write port fed by the training update bus.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module branchTargetBuffer import fetchPkg::*; #(
  parameter int BTB_INDEX_BITS = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [PC_WIDTH-1:0]           pc_i,
  branchUpdateIf.sink                   update_i,
  output slotPred_t [FETCH_WIDTH-1:0]   lookup_o
);

  localparam int ENTRIES  = 2 ** BTB_INDEX_BITS;
  localparam int TAG_BITS = PC_WIDTH - 2 - BTB_INDEX_BITS;

  logic [ENTRIES-1:0]        entryValid;
  logic [TAG_BITS-1:0]       entryTag    [ENTRIES];
  ctrlType_e                 entryType   [ENTRIES];
  logic [PC_WIDTH-1:0]       entryTarget [ENTRIES];
  logic [BTB_INDEX_BITS-1:0] updIndex;
  logic                      writeEn;

  assign updIndex = update_i.updatePc[2 +: BTB_INDEX_BITS];

  // Not-taken conditional branches never allocate.
  assign writeEn = update_i.updateEn &&
                   !(update_i.updateType == ctrlCondBranch && !update_i.updateDir);

  always_ff @(posedge clk) begin
    if (reset) begin
      entryValid <= '0;
    end else if (writeEn) begin
      entryValid[updIndex] <= 1'b1;
    end
  end

  // Whole entry replaced on a write.
  always_ff @(posedge clk) begin
    if (writeEn) begin
      entryTag[updIndex]    <= update_i.updatePc[PC_WIDTH-1 -: TAG_BITS];
      entryType[updIndex]   <= update_i.updateType;
      entryTarget[updIndex] <= update_i.updateTarget;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-slot lookup.
  for (genvar s = 0; s < FETCH_WIDTH; s++) begin : gLookup
    logic [PC_WIDTH-1:0]       slotPc;
    logic [BTB_INDEX_BITS-1:0] slotIndex;

    assign slotPc    = pc_i + PC_WIDTH'(4 * s); // Slot s sits at PC + 4s.
    assign slotIndex = slotPc[2 +: BTB_INDEX_BITS];

    assign lookup_o[s].btbHit   = entryValid[slotIndex] &&
                                  entryTag[slotIndex] == slotPc[PC_WIDTH-1 -: TAG_BITS];
    assign lookup_o[s].ctrlType = entryType[slotIndex];
    assign lookup_o[s].target   = entryTarget[slotIndex];
    assign lookup_o[s].taken    = 1'b0; // Direction comes from the counters.
  end

endmodule

/* rtl/branchPredictor.sv */
////////////////////////////////////////////////////////////////////////////
// Direction predictor: one table of 2-bit saturating counters.
// Four lookups per cycle; trained only by conditional branch updates.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module branchPredictor import fetchPkg::*; #(
  parameter int BP_INDEX_BITS = 6
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [PC_WIDTH-1:0]    pc_i,
  branchUpdateIf.sink            update_i,
  output logic [FETCH_WIDTH-1:0] taken_o
);

  localparam int ENTRIES = 2 ** BP_INDEX_BITS;

  logic [1:0]               counters [ENTRIES];
  logic [BP_INDEX_BITS-1:0] updIndex;
  logic                     trainEn;

  assign updIndex = update_i.updatePc[2 +: BP_INDEX_BITS];
  assign trainEn  = update_i.updateEn && update_i.updateType == ctrlCondBranch;

  // Counters start weakly not-taken.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int e = 0; e < ENTRIES; e++) begin
        counters[e] <= 2'b01;
      end
    end else if (trainEn) begin
      if (update_i.updateDir && counters[updIndex] != 2'b11) begin
        counters[updIndex] <= counters[updIndex] + 2'b01;  // Count up, stop at 3.
      end else if (!update_i.updateDir && counters[updIndex] != 2'b00) begin
        counters[updIndex] <= counters[updIndex] - 2'b01;  // Count down, stop at 0.
      end
    end
  end

  for (genvar s = 0; s < FETCH_WIDTH; s++) begin : gLookup
    logic [PC_WIDTH-1:0] slotPc;

    assign slotPc     = pc_i + PC_WIDTH'(4 * s);
    assign taken_o[s] = counters[slotPc[2 +: BP_INDEX_BITS]][1]; // Upper bit predicts.
  end

endmodule

/* rtl/returnAddressStack.sv */
////////////////////////////////////////////////////////////////////////////
// Circular return address stack.
// Calls push their return address, returns pop; top_o is read combinationally.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module returnAddressStack import fetchPkg::*; #(
  parameter int RAS_DEPTH = 8 // Power of two, so the pointer wraps cleanly.
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                push_i,
  input  logic                pop_i,
  input  logic [PC_WIDTH-1:0] pushAddr_i,
  output logic [PC_WIDTH-1:0] top_o
);

  localparam int PTR_BITS = $clog2(RAS_DEPTH);

  logic [PC_WIDTH-1:0] stackMem [RAS_DEPTH];
  logic [PTR_BITS-1:0] topPtr;
  logic [PTR_BITS-1:0] pushPtr;

  assign pushPtr = topPtr + 1'b1; // Wraps, so overflow drops the oldest entry.

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
      for (int e = 0; e < RAS_DEPTH; e++) begin
        stackMem[e] <= '0;
      end
    end else if (push_i) begin
      stackMem[pushPtr] <= pushAddr_i;
      topPtr            <= pushPtr;
    end else if (pop_i) begin
      topPtr <= topPtr - 1'b1; // Underflow wraps too.
    end
  end

  assign top_o = stackMem[topPtr];

  // Only the first taken slot drives the stack, so it is a call or a return.
  pushPopExclusive: assert property (@(posedge clk) disable iff (reset)
    !(push_i && pop_i));

endmodule

/* rtl/instCache.sv */
////////////////////////////////////////////////////////////////////////////
// Direct-mapped instruction cache with one bundle per 16-byte line.
// A miss refills the line as four single-word Wishbone classic reads.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module instCache import fetchPkg::*; #(
  parameter int CACHE_INDEX_BITS = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [PC_WIDTH-1:0]     pc_i,
  output logic                    hit_o,
  output logic [BUNDLE_WIDTH-1:0] bundle_o,
  output logic                    wbCyc_o,
  output logic                    wbStb_o,
  output logic [PC_WIDTH-1:0]     wbAdr_o,
  input  logic [INST_WIDTH-1:0]   wbDat_i,
  input  logic                    wbAck_i
);

  localparam int LINES     = 2 ** CACHE_INDEX_BITS;
  localparam int BASE_BITS = PC_WIDTH - 4;               // Line address without offset.
  localparam int TAG_BITS  = BASE_BITS - CACHE_INDEX_BITS;
  localparam int BEAT_BITS = $clog2(FETCH_WIDTH);
  localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(FETCH_WIDTH - 1);

  logic [LINES-1:0]            lineValid;
  logic [TAG_BITS-1:0]         lineTag  [LINES];
  logic [BUNDLE_WIDTH-1:0]     lineData [LINES];
  refillState_e                refillState;
  logic [BASE_BITS-1:0]        refillBase;               // Latched at refill start.
  logic [BEAT_BITS-1:0]        beatCnt;
  logic [INST_WIDTH-1:0]       beatBuf [FETCH_WIDTH-1];  // Words before the last.
  logic [CACHE_INDEX_BITS-1:0] refillIndex;
  logic [CACHE_INDEX_BITS-1:0] pcIndex;
  logic                        lineWrite;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup.
  assign pcIndex  = pc_i[4 +: CACHE_INDEX_BITS];
  assign hit_o    = lineValid[pcIndex] && lineTag[pcIndex] == pc_i[PC_WIDTH-1 -: TAG_BITS];
  assign bundle_o = lineData[pcIndex];

  ////////////////////////////////////////////////////////////////////////////
  // Refill FSM.
  assign refillIndex = refillBase[CACHE_INDEX_BITS-1:0];
  assign wbAdr_o     = {refillBase, beatCnt, 2'b00};     // Ascending words of the line.
  assign lineWrite   = refillState == refillRead && wbAck_i && beatCnt == LAST_BEAT;

  always_ff @(posedge clk) begin
    if (reset) begin
      refillState <= refillIdle;
      wbCyc_o     <= 1'b0;
      wbStb_o     <= 1'b0;
      beatCnt     <= '0;
      lineValid   <= '0;
    end else begin
      case (refillState)
        refillIdle: begin
          if (!hit_o) begin                              // Miss seen. Refill next cycle.
            wbCyc_o     <= 1'b1;
            wbStb_o     <= 1'b1;
            beatCnt     <= '0;
            refillState <= refillRead;
          end
        end
        refillRead: begin
          if (wbAck_i) begin
            wbCyc_o <= 1'b0;                             // Drop cyc between beats.
            wbStb_o <= 1'b0;
            beatCnt <= beatCnt + 1'b1;
            if (beatCnt == LAST_BEAT) begin
              lineValid[refillIndex] <= 1'b1;
              refillState            <= refillIdle;
            end else begin
              refillState <= refillDone;
            end
          end
        end
        refillDone: begin
          wbCyc_o     <= 1'b1;                           // Next beat.
          wbStb_o     <= 1'b1;
          refillState <= refillRead;
        end
        default: refillState <= refillIdle;
      endcase
    end
  end

  // Refill payload and the line arrays.
  always_ff @(posedge clk) begin
    if (refillState == refillIdle && !hit_o) begin
      refillBase <= pc_i[PC_WIDTH-1:4];
    end
    if (refillState == refillRead && wbAck_i && beatCnt != LAST_BEAT) begin
      beatBuf[beatCnt] <= wbDat_i;
    end
    if (lineWrite) begin
      lineTag[refillIndex]  <= refillBase[BASE_BITS-1 -: TAG_BITS];
      lineData[refillIndex] <= {wbDat_i, beatBuf[2], beatBuf[1], beatBuf[0]}; // Slot 0 low.
    end
  end

  // Request stays inside cyc with a stable address until the slave acks.
  stbInsideCyc: assert property (@(posedge clk) disable iff (reset)
    wbStb_o |-> wbCyc_o ##1 ($past(wbAck_i) || (wbStb_o && $stable(wbAdr_o))));

endmodule

/* rtl/fetchStage1.sv */
////////////////////////////////////////////////////////////////////////////
// First fetch stage: PC register, next-PC selection and RAS control.
// Owns the BTB, the direction counters, the RAS and the instruction cache.
// Next PC priority is redirect, first taken slot, then PC + 16.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetchStage1 import fetchPkg::*; #(
  parameter int BTB_INDEX_BITS   = 4,
  parameter int BP_INDEX_BITS    = 6,
  parameter int RAS_DEPTH        = 8,
  parameter int CACHE_INDEX_BITS = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           stall_i,
  input  logic                           redirect_i,
  input  logic [PC_WIDTH-1:0]            redirectPc_i,
  branchUpdateIf.sink                    update_i,
  output logic                           fetchValid_o,
  output logic [PC_WIDTH-1:0]            pc_o,
  output logic [BUNDLE_WIDTH-1:0]        bundle_o,
  output logic                           predTaken_o,
  output logic [$clog2(FETCH_WIDTH)-1:0] predSlot_o,
  output logic                           wbCyc_o,
  output logic                           wbStb_o,
  output logic [PC_WIDTH-1:0]            wbAdr_o,
  input  logic [INST_WIDTH-1:0]          wbDat_i,
  input  logic                           wbAck_i
);

  localparam int SLOT_BITS   = $clog2(FETCH_WIDTH);
  localparam int OFFSET_BITS = $clog2(BUNDLE_WIDTH / 8); // Byte offset in a bundle.

  logic [PC_WIDTH-1:0]          pcReg;
  logic [PC_WIDTH-1:0]          nextPc;
  logic [PC_WIDTH-1:0]          predTarget;
  logic [PC_WIDTH-1:0]          rasTop;
  logic [PC_WIDTH-1:0]          pushAddr;
  slotPred_t [FETCH_WIDTH-1:0]  btbLookup;
  slotPred_t [FETCH_WIDTH-1:0]  slotPred;
  slotPred_t                    firstPred;
  logic [FETCH_WIDTH-1:0]       dirTaken;
  logic [FETCH_WIDTH-1:0]       slotTaken;
  logic [SLOT_BITS-1:0]         firstSlot;
  logic                         anyTaken;
  logic                         advance;
  logic                         rasPush;
  logic                         rasPop;

  branchTargetBuffer #(.BTB_INDEX_BITS(BTB_INDEX_BITS)) btb_i (
    .clk(clk), .reset(reset), .pc_i(pcReg), .update_i(update_i), .lookup_o(btbLookup)
  );

  branchPredictor #(.BP_INDEX_BITS(BP_INDEX_BITS)) bp_i (
    .clk(clk), .reset(reset), .pc_i(pcReg), .update_i(update_i), .taken_o(dirTaken)
  );

  returnAddressStack #(.RAS_DEPTH(RAS_DEPTH)) ras_i (
    .clk(clk), .reset(reset), .push_i(rasPush), .pop_i(rasPop),
    .pushAddr_i(pushAddr), .top_o(rasTop)
  );

  instCache #(.CACHE_INDEX_BITS(CACHE_INDEX_BITS)) icache_i (
    .clk(clk), .reset(reset), .pc_i(pcReg), .hit_o(fetchValid_o), .bundle_o(bundle_o),
    .wbCyc_o(wbCyc_o), .wbStb_o(wbStb_o), .wbAdr_o(wbAdr_o),
    .wbDat_i(wbDat_i), .wbAck_i(wbAck_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Slot prediction.
  for (genvar s = 0; s < FETCH_WIDTH; s++) begin : gSlot
    assign slotPred[s] = '{btbHit:   btbLookup[s].btbHit,
                           ctrlType: btbLookup[s].ctrlType,
                           target:   btbLookup[s].target,
                           taken:    dirTaken[s]};
    // Unconditional types are taken on a hit.
    assign slotTaken[s] = slotPred[s].btbHit &&
                          (slotPred[s].ctrlType != ctrlCondBranch || slotPred[s].taken);
  end

  // Lowest taken slot wins.
  always_comb begin
    firstSlot = '0;
    for (int s = FETCH_WIDTH - 1; s >= 0; s--) begin
      if (slotTaken[s]) begin
        firstSlot = SLOT_BITS'(s);
      end
    end
  end

  assign anyTaken   = |slotTaken;
  assign firstPred  = slotPred[firstSlot];
  assign predTarget = (firstPred.ctrlType == ctrlReturn) ? rasTop : firstPred.target;

  // Fetch stays bundle aligned; the target's slot bits are dropped.
  assign nextPc = anyTaken ? {predTarget[PC_WIDTH-1:OFFSET_BITS], OFFSET_BITS'(0)}
                           : pcReg + PC_WIDTH'(BUNDLE_WIDTH / 8);

  ////////////////////////////////////////////////////////////////////////////
  // RAS control, only on an edge where the PC advances.
  assign advance  = fetchValid_o && !stall_i && !redirect_i;
  assign pushAddr = pcReg + PC_WIDTH'({firstSlot, 2'b00}) + PC_WIDTH'(4); // After the call.
  assign rasPush  = advance && anyTaken && firstPred.ctrlType == ctrlCall;
  assign rasPop   = advance && anyTaken && firstPred.ctrlType == ctrlReturn;

  always_ff @(posedge clk) begin
    if (reset) begin
      pcReg <= '0;
    end else if (redirect_i) begin
      pcReg <= redirectPc_i;      // Wins over miss and stall.
    end else if (advance) begin
      pcReg <= nextPc;
    end
  end

  assign pc_o        = pcReg;
  assign predTaken_o = anyTaken;
  assign predSlot_o  = firstSlot;

  // Redirects from execute must land on a bundle as well.
  pcAligned: assert property (@(posedge clk) disable iff (reset)
    pcReg[OFFSET_BITS-1:0] == '0);

endmodule

/* rtl/fetchTop.sv */
////////////////////////////////////////////////////////////////////////////
// Top level of the fetch front end with plain ports.
// Carries the training updates onto the update bus and sets the table sizes.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetchTop import fetchPkg::*; #(
  parameter int BTB_INDEX_BITS   = 4,
  parameter int BP_INDEX_BITS    = 6,
  parameter int RAS_DEPTH        = 8,
  parameter int CACHE_INDEX_BITS = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           stall_i,
  input  logic                           redirect_i,
  input  logic [PC_WIDTH-1:0]            redirectPc_i,
  input  logic                           updateEn_i,
  input  logic [PC_WIDTH-1:0]            updatePc_i,
  input  logic [PC_WIDTH-1:0]            updateTarget_i,
  input  ctrlType_e                      updateType_i,
  input  logic                           updateDir_i,
  input  logic [INST_WIDTH-1:0]          wbDat_i,
  input  logic                           wbAck_i,
  output logic                           fetchValid_o,
  output logic [PC_WIDTH-1:0]            pc_o,
  output logic [BUNDLE_WIDTH-1:0]        bundle_o,
  output logic                           predTaken_o,
  output logic [$clog2(FETCH_WIDTH)-1:0] predSlot_o,
  output logic                           wbCyc_o,
  output logic                           wbStb_o,
  output logic [PC_WIDTH-1:0]            wbAdr_o
);

  branchUpdateIf updBus ();

  // Source side of the update bus.
  assign updBus.updateEn     = updateEn_i;
  assign updBus.updatePc     = updatePc_i;
  assign updBus.updateTarget = updateTarget_i;
  assign updBus.updateType   = updateType_i;
  assign updBus.updateDir    = updateDir_i;

  fetchStage1 #(
    .BTB_INDEX_BITS  (BTB_INDEX_BITS),
    .BP_INDEX_BITS   (BP_INDEX_BITS),
    .RAS_DEPTH       (RAS_DEPTH),
    .CACHE_INDEX_BITS(CACHE_INDEX_BITS)
  ) fs1_i (
    .clk          (clk),
    .reset        (reset),
    .stall_i      (stall_i),
    .redirect_i   (redirect_i),
    .redirectPc_i (redirectPc_i),
    .update_i     (updBus.sink),
    .fetchValid_o (fetchValid_o),
    .pc_o         (pc_o),
    .bundle_o     (bundle_o),
    .predTaken_o  (predTaken_o),
    .predSlot_o   (predSlot_o),
    .wbCyc_o      (wbCyc_o),
    .wbStb_o      (wbStb_o),
    .wbAdr_o      (wbAdr_o),
    .wbDat_i      (wbDat_i),
    .wbAck_i      (wbAck_i)
  );

endmodule

/* verif/fetchTb.sv */
////////////////////////////////////////////////////////////////////////////
// Random-stimulus testbench for the fetch front end.
// A Wishbone memory answers refills. A model of the tables, the RAS and
// the cache tags predicts every output, which is checked each falling edge.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetchTb import fetchPkg::*; ();

  localparam int BTB_BITS    = 4;
  localparam int BP_BITS     = 6;
  localparam int RAS_DEPTH   = 8;
  localparam int CACHE_BITS  = 4;
  localparam int STIM_CYCLES = 3000;
  localparam int TIMEOUT     = STIM_CYCLES + 2000; // Stimulus plus refill margin.

  logic clk, reset, stall, redirect, updateEn, updateDir, wbAck;
  logic [31:0] redirectPc, updatePc, updateTarget, wbDat;
  ctrlType_e updateType;
  logic fetchValid, predTaken, wbCyc, wbStb;
  logic [31:0] pc, wbAdr;
  logic [127:0] bundle;
  logic [1:0] predSlot;

  // Model state.
  logic [31:0] mPc;
  logic        bValid [2**BTB_BITS];
  logic [29-BTB_BITS:0] bTag [2**BTB_BITS];
  logic [1:0]  bType [2**BTB_BITS];
  logic [31:0] bTarget [2**BTB_BITS];
  logic [1:0]  cnt [2**BP_BITS];
  logic [31:0] ras [RAS_DEPTH];
  logic [$clog2(RAS_DEPTH)-1:0] rp;
  logic        cValid [2**CACHE_BITS];
  logic [27-CACHE_BITS:0] cTag [2**CACHE_BITS];
  int          mPhase;                // 0 idle, 1 bus read, 2 gap between beats.
  logic [27:0] mBase;
  logic [1:0]  mBeat;
  int          waitLeft, stimCnt, cycleCnt, errors;
  logic        beatBusy;
  integer      seed;

  fetchTop #(.BTB_INDEX_BITS(BTB_BITS), .BP_INDEX_BITS(BP_BITS),
             .RAS_DEPTH(RAS_DEPTH), .CACHE_INDEX_BITS(CACHE_BITS)) dut_i (
    .clk(clk), .reset(reset), .stall_i(stall), .redirect_i(redirect),
    .redirectPc_i(redirectPc), .updateEn_i(updateEn), .updatePc_i(updatePc),
    .updateTarget_i(updateTarget), .updateType_i(updateType), .updateDir_i(updateDir),
    .wbDat_i(wbDat), .wbAck_i(wbAck), .fetchValid_o(fetchValid), .pc_o(pc),
    .bundle_o(bundle), .predTaken_o(predTaken), .predSlot_o(predSlot),
    .wbCyc_o(wbCyc), .wbStb_o(wbStb), .wbAdr_o(wbAdr)
  );

  always #20 clk = ~clk; // 40 ns period.

  function automatic logic [31:0] memWord(input logic [31:0] a);
    return a ^ 32'h5a5a0000; // Memory contents.
  endfunction

  function automatic logic cacheHit(input logic [31:0] a);
    return cValid[a[4 +: CACHE_BITS]] && cTag[a[4 +: CACHE_BITS]] == a[31:4+CACHE_BITS];
  endfunction

  task automatic checkValue(input string name, input logic [127:0] exp,
                            input logic [127:0] act);
    if (act !== exp) begin
      errors++;
      $display("error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "Output mismatch.");
    end
  endtask

  // First taken slot of the bundle at a, lowest slot wins.
  task automatic predict(input logic [31:0] a, output logic taken, output logic [1:0] slot,
                         output logic [31:0] next, output logic [1:0] kind);
    logic [31:0] sa;
    int bi;
    taken = 1'b0;
    slot  = '0;
    kind  = '0;
    next  = a + 32'd16;                           // Sequential by default.
    for (int s = 3; s >= 0; s--) begin
      sa = a + 32'(4 * s);
      bi = sa[2 +: BTB_BITS];
      if (bValid[bi] && bTag[bi] == sa[31:2+BTB_BITS] &&
          (bType[bi] != ctrlCondBranch || cnt[sa[2 +: BP_BITS]][1])) begin
        taken = 1'b1;
        slot  = 2'(s);
        kind  = bType[bi];
        next  = (bType[bi] == ctrlReturn ? ras[rp] : bTarget[bi]) & ~32'hf;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Model update, memory slave and stimulus, all on the rising edge.
  task automatic stepModel();
    logic taken, hit, adv;
    logic [1:0] slot, kind;
    logic [31:0] next;
    int bi;
    predict(mPc, taken, slot, next, kind);       // Pre-edge state.
    hit = cacheHit(mPc);
    adv = hit && !stall && !redirect;
    case (mPhase)
      0: if (!hit) begin
        mPhase = 1;
        mBase  = mPc[31:4];                      // Line base latched at start.
        mBeat  = '0;
      end
      1: if (wbAck) begin
        if (mBeat == 2'd3) begin
          cValid[mBase[CACHE_BITS-1:0]] = 1'b1;
          cTag[mBase[CACHE_BITS-1:0]]   = mBase[27:CACHE_BITS];
          mPhase = 0;
        end else begin
          mPhase = 2;
        end
        mBeat++;
      end
      default: mPhase = 1;
    endcase
    if (adv && taken && kind == ctrlCall) begin
      rp++;
      ras[rp] = mPc + 32'(4 * slot) + 32'd4;     // Return lands after the call.
    end else if (adv && taken && kind == ctrlReturn) begin
      rp--;
    end
    if (redirect) mPc = redirectPc;
    else if (adv) mPc = next;
    bi = updatePc[2 +: BTB_BITS];
    if (updateEn && !(updateType == ctrlCondBranch && !updateDir)) begin
      bValid[bi]  = 1'b1;
      bTag[bi]    = updatePc[31:2+BTB_BITS];
      bType[bi]   = updateType;
      bTarget[bi] = updateTarget;
    end
    bi = updatePc[2 +: BP_BITS];
    if (updateEn && updateType == ctrlCondBranch) begin
      if (updateDir && cnt[bi] != 2'd3) cnt[bi]++;
      else if (!updateDir && cnt[bi] != 2'd0) cnt[bi]--;
    end
  endtask

  task automatic resetModel();
    mPc = '0;
    rp = '0;
    mPhase = 0;
    beatBusy = 1'b0;
    foreach (bValid[i]) bValid[i] = 1'b0;
    foreach (cValid[i]) cValid[i] = 1'b0;
    foreach (cnt[i]) cnt[i] = 2'b01;             // Weakly not-taken.
    foreach (ras[i]) ras[i] = '0;
  endtask

  task automatic serveBus();
    if (wbAck) begin
      wbAck <= 1'b0;                             // One ack per beat.
      beatBusy = 1'b0;
    end else if (wbCyc && wbStb) begin
      if (!beatBusy) begin
        beatBusy = 1'b1;
        waitLeft = {$random(seed)} % 4;          // 0 to 3 wait cycles.
      end
      if (waitLeft == 0) begin
        wbAck <= 1'b1;
        wbDat <= memWord(wbAdr);
      end else begin
        waitLeft--;
      end
    end
  endtask

  task automatic driveStimulus();
    if (stimCnt < STIM_CYCLES) begin
      stall        <= ({$random(seed)} % 8) == 0;
      redirect     <= ({$random(seed)} % 20) == 0;
      redirectPc   <= 32'({$random(seed)} % 64) << 4;   // Bundle in the first 1 KB.
      updateEn     <= ({$random(seed)} % 3) == 0;
      updatePc     <= 32'({$random(seed)} % 256) << 2;  // Slot address.
      updateTarget <= 32'({$random(seed)} % 256) << 2;
      updateType   <= ctrlType_e'($random(seed));
      updateDir    <= $random(seed);
      stimCnt++;
    end else begin
      stall    <= 1'b0;
      redirect <= 1'b0;
      updateEn <= 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      resetModel();
      wbAck <= 1'b0;
    end else begin
      stepModel();
      serveBus();
      driveStimulus();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output checks on the falling edge, where everything is settled.
  always @(negedge clk) begin : compareOutputs
    logic taken;
    logic [1:0] slot, kind;
    logic [31:0] next;
    if (cycleCnt > 0) begin
      predict(mPc, taken, slot, next, kind);
      checkValue("pc_o", mPc, pc);
      checkValue("fetchValid_o", cacheHit(mPc), fetchValid);
      if (cacheHit(mPc)) begin
        checkValue("bundle_o", {memWord(mPc + 32'd12), memWord(mPc + 32'd8),
                                memWord(mPc + 32'd4), memWord(mPc)}, bundle);
      end
      checkValue("predTaken_o", taken, predTaken);
      if (taken) checkValue("predSlot_o", slot, predSlot);
      checkValue("wbCyc_o", mPhase == 1, wbCyc);   // Low between beats.
      checkValue("wbStb_o", mPhase == 1, wbStb);
      if (mPhase == 1) checkValue("wbAdr_o", {mBase, mBeat, 2'b00}, wbAdr);
    end
  end

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt >= TIMEOUT) begin
      $display("error at %0t ns: run hung, no end after %0d cycles", $time, cycleCnt);
      $display("TESTS FAILED");
      $fatal(1, "Timeout.");
    end
  end

  initial begin
    seed = 32'h37ee;
    clk = 1'b0;
    reset = 1'b1;
    stall = 1'b0;
    redirect = 1'b0;
    redirectPc = '0;
    updateEn = 1'b0;
    updatePc = '0;
    updateTarget = '0;
    updateType = ctrlReturn;
    updateDir = 1'b0;
    wbDat = '0;
    wbAck = 1'b0;
    stimCnt = 0;
    cycleCnt = 0;
    errors = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    wait (stimCnt == STIM_CYCLES);
    do @(negedge clk); while (mPhase != 0);      // Let the last refill finish.
    if (errors == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "Errors seen.");
    end
  end

endmodule

/* files.f */
rtl/fetchPkg.sv
rtl/branchUpdateIf.sv
rtl/branchTargetBuffer.sv
rtl/branchPredictor.sv
rtl/returnAddressStack.sv
rtl/instCache.sv
rtl/fetchStage1.sv
rtl/fetchTop.sv
verif/fetchTb.sv
